// File: can_pkg.sv
/* Widths, types, register map and frame constants shared by the
   CAN transmit controller; blocks refer to them by scoped name */
`default_nettype none

package can_pkg;

    // Frame field widths
    localparam int unsigned ID_BASE_BITS   = 11;
    localparam int unsigned ID_EXT_BITS    = 18;
    localparam int unsigned ID_BITS        = ID_BASE_BITS + ID_EXT_BITS;
    localparam int unsigned DLC_BITS       = 4;
    localparam int unsigned MAX_DATA_BYTES = 8;
    localparam int unsigned CRC_BITS       = 15;
    localparam int unsigned STUFF_LIMIT    = 5;
    localparam int unsigned EOF_BITS       = 7;
    localparam int unsigned IFS_BITS       = 3;
    localparam int unsigned BRP_BITS       = 10;
    localparam int unsigned WB_BITS        = 32;

    typedef logic [ID_BITS-1:0]          can_id_t;
    typedef logic [DLC_BITS-1:0]         can_dlc_t;
    typedef logic [MAX_DATA_BYTES*8-1:0] can_data_t;
    typedef logic [CRC_BITS-1:0]         can_crc_t;
    typedef logic [BRP_BITS-1:0]         can_brp_t;
    typedef logic [WB_BITS-1:0]          wb_data_t;
    typedef logic [WB_BITS-1:0]          wb_addr_t;
    typedef logic [7:0]                  wb_off_t;

    // CAN generator polynomial x^15+x^14+x^10+x^8+x^7+x^4+x^3+1
    localparam can_crc_t CRC_POLY = 15'h4599;

    // Register byte offsets
    localparam wb_off_t REG_CTRL    = 8'h00;
    localparam wb_off_t REG_STATUS  = 8'h04;
    localparam wb_off_t REG_BRP     = 8'h08;
    localparam wb_off_t REG_ID      = 8'h0C;
    localparam wb_off_t REG_DLC     = 8'h10;
    localparam wb_off_t REG_DATA_LO = 8'h14;
    localparam wb_off_t REG_DATA_HI = 8'h18;

    // Frame fields in transmit order
    typedef enum logic [4:0] {
        FLD_IDLE, FLD_SOF, FLD_ID_BASE, FLD_SRR_RTR, FLD_IDE, FLD_ID_EXT,
        FLD_RTR_EXT, FLD_R1, FLD_R0, FLD_DLC, FLD_DATA, FLD_CRC, FLD_CRC_DELIM,
        FLD_ACK_SLOT, FLD_ACK_DELIM, FLD_EOF, FLD_IFS
    } frame_field_e;

endpackage

`default_nettype wire

// File: can_mbox_if.sv
/* Mailbox contents and transmit handshake from the register block
   to the frame builder */
`timescale 1ns/1ps
`default_nettype none

interface can_mbox_if;

    // Mailbox, stable while busy
    can_pkg::can_id_t   id;
    logic               ext;
    logic               rtr;
    can_pkg::can_dlc_t  dlc;
    can_pkg::can_data_t data;

    // One-cycle transmit request
    logic start;

    // Frame in flight, and end-of-frame pulse
    logic busy;
    logic done;

    modport regs (
        output id, ext, rtr, dlc, data, start,
        input  busy, done
    );

    modport framer (
        input  id, ext, rtr, dlc, data, start,
        output busy, done
    );

endinterface

`default_nettype wire

// File: can_bit_if.sv
/* Unstuffed frame bit stream from the frame builder to the stuffer,
   with a take handshake per bit */
`timescale 1ns/1ps
`default_nettype none

interface can_bit_if;

    logic tx_bit;
    logic valid;
    // Bit is inside the stuffed region, SOF to CRC
    logic stuffable;
    // Offered bit goes on the bus this strobe
    logic take;

    modport framer (
        output tx_bit, valid, stuffable,
        input  take
    );

    modport stuffer (
        input  tx_bit, valid, stuffable,
        output take
    );

endinterface

`default_nettype wire

// File: can_wb_regs.sv
/* Wishbone classic slave with the prescaler, the transmit mailbox
   and the control and status registers */
`timescale 1ns/1ps
`default_nettype none

module can_wb_regs (
    input  wire logic              tb_wb_clk_i,
    input  wire logic              rst_n_i,
    input  wire can_pkg::wb_addr_t wb_adr_i,
    input  wire can_pkg::wb_data_t wb_dat_i,
    input  wire logic [3:0]        wb_sel_i,
    input  wire logic              wb_we_i,
    input  wire logic              wb_cyc_i,
    input  wire logic              wb_stb_i,
    output logic                   wb_ack_o,
    output can_pkg::wb_data_t      wb_dat_o,
    output can_pkg::can_brp_t      brp_o,
    can_mbox_if.regs               mbox
);

    // Byte-lane merge of a write into the current register word
    function automatic can_pkg::wb_data_t lane_merge(
        input can_pkg::wb_data_t old_w,
        input can_pkg::wb_data_t new_w,
        input logic [3:0]        sel
    );
        can_pkg::wb_data_t res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                res[i*8 +: 8] = new_w[i*8 +: 8];
            end
        end
        return res;
    endfunction

    can_pkg::wb_off_t   offset;
    can_pkg::wb_data_t  rd_word;
    can_pkg::wb_data_t  wr_word;
    logic               wr_en;
    logic               done_q;
    logic               start_q;
    can_pkg::can_brp_t  brp_q;
    can_pkg::can_id_t   id_q;
    logic               ext_q;
    logic               rtr_q;
    can_pkg::can_dlc_t  dlc_q;
    can_pkg::can_data_t data_q;

    assign offset = wb_adr_i[7:0];
    // New request only, ack cycle excluded
    assign wr_en  = wb_cyc_i && wb_stb_i && !wb_ack_o && wb_we_i;

    // Readback mux, unused bits zero
    always_comb begin
        case (offset)
            can_pkg::REG_STATUS:  rd_word = {30'd0, done_q, mbox.busy};
            can_pkg::REG_BRP:     rd_word = {22'd0, brp_q};
            can_pkg::REG_ID:      rd_word = {1'b0, rtr_q, ext_q, id_q};
            can_pkg::REG_DLC:     rd_word = {28'd0, dlc_q};
            can_pkg::REG_DATA_LO: rd_word = data_q[31:0];
            can_pkg::REG_DATA_HI: rd_word = data_q[63:32];
            default:              rd_word = '0;
        endcase
    end

    assign wr_word  = lane_merge(rd_word, wb_dat_i, wb_sel_i);
    assign wb_dat_o = rd_word;

    // **************************************************
    // Bus handshake, control and status
    // **************************************************
    always_ff @(posedge tb_wb_clk_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
            start_q  <= 1'b0;
            done_q   <= 1'b0;
            brp_q    <= '0;
        end else begin
            wb_ack_o <= wb_cyc_i && wb_stb_i && !wb_ack_o;
            // Request while idle only
            start_q  <= wr_en && (offset == can_pkg::REG_CTRL) && wb_sel_i[0]
                        && wb_dat_i[0] && !mbox.busy;
            // Sticky done, set wins over clear
            if (mbox.done) begin
                done_q <= 1'b1;
            end else if (wr_en && (offset == can_pkg::REG_STATUS) && wb_sel_i[0]
                         && wb_dat_i[1]) begin
                done_q <= 1'b0;
            end
            if (wr_en && (offset == can_pkg::REG_BRP)) begin
                brp_q <= wr_word[9:0];
            end
        end
    end

    // Mailbox locked during a frame
    always_ff @(posedge tb_wb_clk_i) begin
        if (wr_en && !mbox.busy) begin
            case (offset)
                can_pkg::REG_ID: begin
                    id_q  <= wr_word[28:0];
                    ext_q <= wr_word[29];
                    rtr_q <= wr_word[30];
                end
                can_pkg::REG_DLC:     dlc_q         <= wr_word[3:0];
                can_pkg::REG_DATA_LO: data_q[31:0]  <= wr_word;
                can_pkg::REG_DATA_HI: data_q[63:32] <= wr_word;
                default: ;
            endcase
        end
    end

    assign brp_o      = brp_q;
    assign mbox.id    = id_q;
    assign mbox.ext   = ext_q;
    assign mbox.rtr   = rtr_q;
    assign mbox.dlc   = dlc_q;
    assign mbox.data  = data_q;
    assign mbox.start = start_q;

endmodule

`default_nettype wire

// File: can_bit_timer.sv
/* Free-running prescaler, one strobe every BRP+1 clocks */
`timescale 1ns/1ps
`default_nettype none

module can_bit_timer (
    input  wire logic              tb_wb_clk_i,
    input  wire logic              rst_n_i,
    input  wire can_pkg::can_brp_t brp_i,
    output logic                   strobe_o
);

    can_pkg::can_brp_t cnt_q;

    // Strobe at terminal count
    assign strobe_o = (cnt_q == '0);

    always_ff @(posedge tb_wb_clk_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (strobe_o) begin
            // New BRP picked up here
            cnt_q <= brp_i;
        end else begin
            cnt_q <= cnt_q - 10'd1;
        end
    end

endmodule

`default_nettype wire

// File: can_crc15.sv
/* CAN CRC-15 over the unstuffed bits, cleared at frame start */
`timescale 1ns/1ps
`default_nettype none

module can_crc15 (
    input  wire logic         tb_wb_clk_i,
    input  wire logic         rst_n_i,
    input  wire logic         clear_i,
    input  wire logic         shift_i,
    input  wire logic         bit_i,
    output can_pkg::can_crc_t crc_o
);

    logic fb;

    // Feedback of incoming bit against CRC MSB
    assign fb = bit_i ^ crc_o[can_pkg::CRC_BITS-1];

    always_ff @(posedge tb_wb_clk_i) begin
        if (!rst_n_i || clear_i) begin
            crc_o <= '0;
        end else if (shift_i) begin
            crc_o <= {crc_o[13:0], 1'b0} ^ (can_pkg::CRC_POLY & {15{fb}});
        end
    end

endmodule

`default_nettype wire

// File: can_tx_framer.sv
/* Frame builder: walks the CAN fields from SOF to intermission and
   offers one unstuffed bit at a time to the stuffer */
`timescale 1ns/1ps
`default_nettype none

module can_tx_framer (
    input  wire logic              tb_wb_clk_i,
    input  wire logic              rst_n_i,
    can_mbox_if.framer             mbox,
    can_bit_if.framer              tx,
    output logic                   crc_clear_o,
    output logic                   crc_shift_o,
    output logic                   crc_bit_o,
    input  wire can_pkg::can_crc_t crc_i
);

    can_pkg::frame_field_e field_q;
    can_pkg::frame_field_e field_nxt;
    logic [5:0]            cnt_q;
    logic [6:0]            field_len;
    logic                  field_last;
    logic                  bit_val;
    logic                  done_q;
    can_pkg::can_dlc_t     n_bytes;

    // DLC above 8 still sends 8 bytes
    assign n_bytes = (mbox.dlc > can_pkg::can_dlc_t'(can_pkg::MAX_DATA_BYTES)) ?
                     can_pkg::can_dlc_t'(can_pkg::MAX_DATA_BYTES) : mbox.dlc;

    // **************************************************
    // Field length, bit value and successor
    // **************************************************
    always_comb begin
        field_len = 7'd1;
        field_nxt = can_pkg::FLD_IDLE;
        bit_val   = 1'b1;
        case (field_q)
            can_pkg::FLD_SOF: begin
                bit_val   = 1'b0;
                field_nxt = can_pkg::FLD_ID_BASE;
            end
            can_pkg::FLD_ID_BASE: begin
                field_len = 7'(can_pkg::ID_BASE_BITS);
                bit_val   = mbox.id[5'(can_pkg::ID_BITS - 1) - cnt_q[4:0]];
                field_nxt = can_pkg::FLD_SRR_RTR;
            end
            // SRR recessive in extended frames
            can_pkg::FLD_SRR_RTR: begin
                bit_val   = mbox.ext | mbox.rtr;
                field_nxt = can_pkg::FLD_IDE;
            end
            can_pkg::FLD_IDE: begin
                bit_val   = mbox.ext;
                field_nxt = mbox.ext ? can_pkg::FLD_ID_EXT : can_pkg::FLD_R0;
            end
            can_pkg::FLD_ID_EXT: begin
                field_len = 7'(can_pkg::ID_EXT_BITS);
                bit_val   = mbox.id[5'(can_pkg::ID_EXT_BITS - 1) - cnt_q[4:0]];
                field_nxt = can_pkg::FLD_RTR_EXT;
            end
            can_pkg::FLD_RTR_EXT: begin
                bit_val   = mbox.rtr;
                field_nxt = can_pkg::FLD_R1;
            end
            can_pkg::FLD_R1: begin
                bit_val   = 1'b0;
                field_nxt = can_pkg::FLD_R0;
            end
            can_pkg::FLD_R0: begin
                bit_val   = 1'b0;
                field_nxt = can_pkg::FLD_DLC;
            end
            // Raw DLC on the wire, data skipped for RTR
            can_pkg::FLD_DLC: begin
                field_len = 7'(can_pkg::DLC_BITS);
                bit_val   = mbox.dlc[~cnt_q[1:0]];
                field_nxt = (mbox.rtr || n_bytes == '0) ? can_pkg::FLD_CRC
                                                        : can_pkg::FLD_DATA;
            end
            // Byte 0 first, MSB first within a byte
            can_pkg::FLD_DATA: begin
                field_len = {n_bytes, 3'b000};
                bit_val   = mbox.data[{cnt_q[5:3], ~cnt_q[2:0]}];
                field_nxt = can_pkg::FLD_CRC;
            end
            can_pkg::FLD_CRC: begin
                field_len = 7'(can_pkg::CRC_BITS);
                bit_val   = crc_i[4'(can_pkg::CRC_BITS - 1) - cnt_q[3:0]];
                field_nxt = can_pkg::FLD_CRC_DELIM;
            end
            can_pkg::FLD_CRC_DELIM: field_nxt = can_pkg::FLD_ACK_SLOT;
            // Recessive ACK slot, no ACK check
            can_pkg::FLD_ACK_SLOT:  field_nxt = can_pkg::FLD_ACK_DELIM;
            can_pkg::FLD_ACK_DELIM: field_nxt = can_pkg::FLD_EOF;
            can_pkg::FLD_EOF: begin
                field_len = 7'(can_pkg::EOF_BITS);
                field_nxt = can_pkg::FLD_IFS;
            end
            can_pkg::FLD_IFS: field_len = 7'(can_pkg::IFS_BITS);
            default: ;
        endcase
    end

    assign field_last = ({1'b0, cnt_q} == field_len - 7'd1);

    // FSM, advances on every taken bit
    always_ff @(posedge tb_wb_clk_i) begin
        if (!rst_n_i) begin
            field_q <= can_pkg::FLD_IDLE;
            cnt_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (field_q == can_pkg::FLD_IDLE) begin
                if (mbox.start) begin
                    field_q <= can_pkg::FLD_SOF;
                    cnt_q   <= '0;
                end
            end else if (tx.take) begin
                if (field_last) begin
                    field_q <= field_nxt;
                    cnt_q   <= '0;
                    done_q  <= (field_q == can_pkg::FLD_IFS);
                end else begin
                    cnt_q <= cnt_q + 6'd1;
                end
            end
        end
    end

    assign tx.tx_bit    = bit_val;
    assign tx.valid     = (field_q != can_pkg::FLD_IDLE);
    assign tx.stuffable = (field_q >= can_pkg::FLD_SOF) && (field_q <= can_pkg::FLD_CRC);
    assign mbox.busy    = (field_q != can_pkg::FLD_IDLE);
    assign mbox.done    = done_q;

    // CRC covers SOF through the last data bit
    assign crc_clear_o = mbox.start && (field_q == can_pkg::FLD_IDLE);
    assign crc_shift_o = tx.take && (field_q >= can_pkg::FLD_SOF)
                         && (field_q <= can_pkg::FLD_DATA);
    assign crc_bit_o   = bit_val;

endmodule

`default_nettype wire

// File: can_bit_stuffer.sv
/* Bus driver: one bit per strobe, with a complement stuff bit after
   five equal bits in the stuffed region */
`timescale 1ns/1ps
`default_nettype none

module can_bit_stuffer (
    input  wire logic tb_wb_clk_i,
    input  wire logic rst_n_i,
    input  wire logic strobe_i,
    can_bit_if.stuffer tx,
    output logic      can_tx_o
);

    logic [2:0] run_q;
    logic       last_q;
    logic       stuff_now;

    // Run of five, stuff before whatever comes next
    assign stuff_now = tx.valid && (run_q == 3'(can_pkg::STUFF_LIMIT));
    assign tx.take   = strobe_i && tx.valid && !stuff_now;

    always_ff @(posedge tb_wb_clk_i) begin
        if (!rst_n_i) begin
            can_tx_o <= 1'b1;
            last_q   <= 1'b1;
            run_q    <= '0;
        end else if (strobe_i) begin
            if (!tx.valid) begin
                // Idle bus is recessive
                can_tx_o <= 1'b1;
                run_q    <= '0;
            end else if (stuff_now) begin
                can_tx_o <= ~last_q;
                last_q   <= ~last_q;
                run_q    <= 3'd1;
            end else begin
                can_tx_o <= tx.tx_bit;
                last_q   <= tx.tx_bit;
                if (!tx.stuffable) begin
                    run_q <= '0;
                end else if (run_q != '0 && tx.tx_bit == last_q) begin
                    run_q <= run_q + 3'd1;
                end else begin
                    run_q <= 3'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: can_tx_top.sv
/* CAN 2.0B transmit controller, Wishbone register port in and
   serial CAN frame out */
`timescale 1ns/1ps
`default_nettype none

module can_tx_top (
    input  wire logic              tb_wb_clk_i,
    input  wire logic              rst_n_i,
    input  wire can_pkg::wb_addr_t wb_adr_i,
    input  wire can_pkg::wb_data_t wb_dat_i,
    input  wire logic [3:0]        wb_sel_i,
    input  wire logic              wb_we_i,
    input  wire logic              wb_cyc_i,
    input  wire logic              wb_stb_i,
    output logic                   wb_ack_o,
    output can_pkg::wb_data_t      wb_dat_o,
    output logic                   can_tx_o
);

    can_mbox_if mbox ();
    can_bit_if  bits ();

    can_pkg::can_brp_t brp;
    can_pkg::can_crc_t crc;
    logic              strobe;
    logic              crc_clear;
    logic              crc_shift;
    logic              crc_bit;

    // **************************************************
    // Register port and bit clocking
    // **************************************************
    can_wb_regs i_can_wb_regs (
        .tb_wb_clk_i (tb_wb_clk_i),
        .rst_n_i     (rst_n_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_sel_i    (wb_sel_i),
        .wb_we_i     (wb_we_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_ack_o    (wb_ack_o),
        .wb_dat_o    (wb_dat_o),
        .brp_o       (brp),
        .mbox        (mbox.regs)
    );

    can_bit_timer i_can_bit_timer (
        .tb_wb_clk_i (tb_wb_clk_i),
        .rst_n_i     (rst_n_i),
        .brp_i       (brp),
        .strobe_o    (strobe)
    );

    // Frame path
    can_tx_framer i_can_tx_framer (
        .tb_wb_clk_i (tb_wb_clk_i),
        .rst_n_i     (rst_n_i),
        .mbox        (mbox.framer),
        .tx          (bits.framer),
        .crc_clear_o (crc_clear),
        .crc_shift_o (crc_shift),
        .crc_bit_o   (crc_bit),
        .crc_i       (crc)
    );

    can_crc15 i_can_crc15 (
        .tb_wb_clk_i (tb_wb_clk_i),
        .rst_n_i     (rst_n_i),
        .clear_i     (crc_clear),
        .shift_i     (crc_shift),
        .bit_i       (crc_bit),
        .crc_o       (crc)
    );

    can_bit_stuffer i_can_bit_stuffer (
        .tb_wb_clk_i (tb_wb_clk_i),
        .rst_n_i     (rst_n_i),
        .strobe_i    (strobe),
        .tx          (bits.stuffer),
        .can_tx_o    (can_tx_o)
    );

endmodule

`default_nettype wire

// File: tb_can_tx.sv
/* Random-stimulus testbench for the CAN transmit controller: drives the
   Wishbone port, builds each expected frame and checks can_tx_o bit by bit */
`timescale 1ns/1ps
`default_nettype none

module tb_can_tx;

    localparam int FRAMES         = 40;
    // Frames x longest frame x slowest bit time, plus setup
    localparam int TIMEOUT_CYCLES = FRAMES * 200 * 9 + 2000;
    // CAN generator polynomial
    localparam logic [14:0] CAN_POLY = 15'h4599;

    logic        tb_wb_clk_i;
    logic        rst_n_i;
    logic [31:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [3:0]  wb_sel_i;
    logic        wb_we_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_ack_o;
    logic [31:0] wb_dat_o;
    logic        can_tx_o;

    int mismatch_cnt = 0;
    int fail_cnt     = 0;
    int cycle_cnt    = 0;

    // Expected bus levels of the current frame, stuff bits included
    logic exp_q[$];

    // Mailbox model, what the DUT should send
    logic [28:0] m_id;
    logic        m_ext;
    logic        m_rtr;
    logic [3:0]  m_dlc;
    logic [63:0] m_data;
    int          m_brp;

    can_tx_top i_can_tx_top (
        .tb_wb_clk_i (tb_wb_clk_i),
        .rst_n_i     (rst_n_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_sel_i    (wb_sel_i),
        .wb_we_i     (wb_we_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_ack_o    (wb_ack_o),
        .wb_dat_o    (wb_dat_o),
        .can_tx_o    (can_tx_o)
    );

    // 4 ns clock
    always #2 tb_wb_clk_i = ~tb_wb_clk_i;

    // Watchdog
    always @(posedge tb_wb_clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run exceeded %0d clock cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        mismatch_cnt++;
        $display("Mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    endtask

    task automatic flag_error(input string msg);
        fail_cnt++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    // **************************************************
    // Wishbone classic single cycles
    // **************************************************
    task automatic write_reg(input logic [7:0] off, input logic [31:0] dat,
                             input logic [3:0] sel);
        int n;
        n = 0;
        @(posedge tb_wb_clk_i);
        wb_adr_i <= {24'd0, off};
        wb_dat_i <= dat;
        wb_sel_i <= sel;
        wb_we_i  <= 1'b1;
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        @(negedge tb_wb_clk_i);
        while (wb_ack_o !== 1'b1 && n < 16) begin
            n++;
            @(negedge tb_wb_clk_i);
        end
        if (wb_ack_o !== 1'b1) flag_error("No Wishbone ack on a write");
        // Strobe low for at least one cycle
        @(posedge tb_wb_clk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] off, output logic [31:0] dat);
        int n;
        n   = 0;
        dat = '0;
        @(posedge tb_wb_clk_i);
        wb_adr_i <= {24'd0, off};
        wb_sel_i <= 4'hF;
        wb_we_i  <= 1'b0;
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        @(negedge tb_wb_clk_i);
        while (wb_ack_o !== 1'b1 && n < 16) begin
            n++;
            @(negedge tb_wb_clk_i);
        end
        if (wb_ack_o !== 1'b1) flag_error("No Wishbone ack on a read");
        // Data valid during ack
        dat = wb_dat_o;
        @(posedge tb_wb_clk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
    endtask

    // **************************************************
    // Frame model
    // **************************************************
    task automatic build_expected();
        logic        raw[$];
        logic [14:0] crc;
        logic        fb;
        logic        prev;
        int          run;
        int          nb;
        raw = {};
        raw.push_back(1'b0);
        for (int i = 28; i >= 18; i--) raw.push_back(m_id[i]);
        if (m_ext) begin
            // SRR and IDE recessive, then extension, RTR, r1, r0
            raw.push_back(1'b1);
            raw.push_back(1'b1);
            for (int i = 17; i >= 0; i--) raw.push_back(m_id[i]);
            raw.push_back(m_rtr);
            raw.push_back(1'b0);
            raw.push_back(1'b0);
        end else begin
            raw.push_back(m_rtr);
            raw.push_back(1'b0);
            raw.push_back(1'b0);
        end
        for (int k = 3; k >= 0; k--) raw.push_back(m_dlc[k]);
        // No data in RTR frames, at most 8 bytes otherwise
        nb = m_rtr ? 0 : ((m_dlc > 4'd8) ? 8 : int'(m_dlc));
        for (int b = 0; b < nb; b++) begin
            for (int k = 7; k >= 0; k--) raw.push_back(m_data[b*8 + k]);
        end
        crc = '0;
        foreach (raw[i]) begin
            fb  = raw[i] ^ crc[14];
            crc = {crc[13:0], 1'b0};
            if (fb) crc = crc ^ CAN_POLY;
        end
        for (int i = 14; i >= 0; i--) raw.push_back(crc[i]);
        // Stuff after every fifth equal bit, SOF through CRC
        exp_q = {};
        run   = 0;
        prev  = 1'b1;
        foreach (raw[i]) begin
            exp_q.push_back(raw[i]);
            if (run > 0 && raw[i] == prev) run++;
            else run = 1;
            prev = raw[i];
            if (run == 5) begin
                exp_q.push_back(~prev);
                prev = ~prev;
                run  = 1;
            end
        end
        // CRC delimiter, ACK slot, ACK delimiter, EOF, intermission
        for (int i = 0; i < 13; i++) exp_q.push_back(1'b1);
    endtask

    // Checks every clock of every bit, so each bit must last BRP+1 clocks
    task automatic sample_frame();
        int wait_cnt;
        int per;
        per      = m_brp + 1;
        wait_cnt = 0;
        @(negedge tb_wb_clk_i);
        while (can_tx_o === 1'b1 && wait_cnt < 200) begin
            wait_cnt++;
            @(negedge tb_wb_clk_i);
        end
        if (can_tx_o !== 1'b0) begin
            flag_error("No start of frame on can_tx_o");
            return;
        end
        if (wait_cnt > per) flag_error("Start of frame later than BRP+2 clocks after ack");
        for (int i = 0; i < exp_q.size(); i++) begin
            for (int k = 0; k < per; k++) begin
                if (i > 0 || k > 0) @(negedge tb_wb_clk_i);
                if (can_tx_o !== exp_q[i]) begin
                    show_mismatch($sformatf("can_tx_o bit %0d", i), 32'(can_tx_o),
                                  32'(exp_q[i]));
                    return;
                end
            end
        end
    endtask

    task automatic send_frame(input logic load, input logic busy_test);
        logic [31:0] rd;
        int          polls;
        if (load) begin
            write_reg(can_pkg::REG_BRP, 32'(m_brp), 4'hF);
            write_reg(can_pkg::REG_ID, {1'b0, m_rtr, m_ext, m_id}, 4'hF);
            write_reg(can_pkg::REG_DLC, {28'd0, m_dlc}, 4'hF);
            write_reg(can_pkg::REG_DATA_LO, m_data[31:0], 4'hF);
            write_reg(can_pkg::REG_DATA_HI, m_data[63:32], 4'hF);
        end
        build_expected();
        write_reg(can_pkg::REG_CTRL, 32'h1, 4'h1);
        fork
            sample_frame();
            begin
                if (busy_test) begin
                    read_reg(can_pkg::REG_STATUS, rd);
                    if (rd[0] !== 1'b1) show_mismatch("STATUS.busy", 32'(rd[0]), 32'd1);
                    // All of these must be ignored while busy
                    write_reg(can_pkg::REG_CTRL, 32'h1, 4'h1);
                    write_reg(can_pkg::REG_ID, $urandom, 4'hF);
                    write_reg(can_pkg::REG_DLC, $urandom, 4'hF);
                    write_reg(can_pkg::REG_DATA_LO, $urandom, 4'hF);
                    write_reg(can_pkg::REG_DATA_HI, $urandom, 4'hF);
                end
            end
        join
        rd    = '0;
        polls = 0;
        while (rd[1] !== 1'b1 && polls < 64) begin
            read_reg(can_pkg::REG_STATUS, rd);
            polls++;
        end
        if (rd[1] !== 1'b1) flag_error("Done flag not set after the frame");
        if (rd[0] !== 1'b0) show_mismatch("STATUS.busy", 32'(rd[0]), 32'd0);
        // Done is write-1-to-clear
        write_reg(can_pkg::REG_STATUS, 32'h2, 4'h1);
        read_reg(can_pkg::REG_STATUS, rd);
        if (rd !== 32'd0) show_mismatch("STATUS", rd, 32'd0);
        if (busy_test) begin
            // Bus stays idle, the second request was dropped
            for (int k = 0; k < 20 * (m_brp + 1); k++) begin
                @(negedge tb_wb_clk_i);
                if (can_tx_o !== 1'b1) begin
                    flag_error("Transmit request during busy started a frame");
                    break;
                end
            end
        end
    endtask

    // **************************************************
    // Test sequence
    // **************************************************
    initial begin
        logic [31:0] rd;
        logic [31:0] val;
        logic [31:0] merged;
        logic [3:0]  sel;
        logic        load;
        void'($urandom(32'h6822_05d6));
        tb_wb_clk_i = 1'b0;
        rst_n_i     = 1'b0;
        wb_adr_i    = '0;
        wb_dat_i    = '0;
        wb_sel_i    = '0;
        wb_we_i     = 1'b0;
        wb_cyc_i    = 1'b0;
        wb_stb_i    = 1'b0;
        repeat (10) @(posedge tb_wb_clk_i);
        rst_n_i <= 1'b1;
        @(negedge tb_wb_clk_i);
        if (can_tx_o !== 1'b1) show_mismatch("can_tx_o", 32'(can_tx_o), 32'd1);

        // Reset values and unmapped offsets
        read_reg(can_pkg::REG_STATUS, rd);
        if (rd !== 32'd0) show_mismatch("STATUS", rd, 32'd0);
        read_reg(can_pkg::REG_BRP, rd);
        if (rd !== 32'd0) show_mismatch("BRP", rd, 32'd0);
        read_reg(can_pkg::REG_CTRL, rd);
        if (rd !== 32'd0) show_mismatch("CTRL", rd, 32'd0);
        read_reg(8'h1C, rd);
        if (rd !== 32'd0) show_mismatch("unmapped 0x1C", rd, 32'd0);

        // Readback masked to field widths
        val = $urandom;
        write_reg(can_pkg::REG_BRP, val, 4'hF);
        read_reg(can_pkg::REG_BRP, rd);
        if (rd !== (val & 32'h3FF)) show_mismatch("BRP", rd, val & 32'h3FF);
        val = $urandom;
        write_reg(can_pkg::REG_ID, val, 4'hF);
        read_reg(can_pkg::REG_ID, rd);
        if (rd !== (val & 32'h7FFF_FFFF)) show_mismatch("ID", rd, val & 32'h7FFF_FFFF);
        val = $urandom;
        write_reg(can_pkg::REG_DLC, val, 4'hF);
        read_reg(can_pkg::REG_DLC, rd);
        if (rd !== (val & 32'hF)) show_mismatch("DLC", rd, val & 32'hF);
        val = $urandom;
        write_reg(can_pkg::REG_DATA_LO, val, 4'hF);
        read_reg(can_pkg::REG_DATA_LO, rd);
        if (rd !== val) show_mismatch("DATA_LO", rd, val);
        merged = $urandom;
        write_reg(can_pkg::REG_DATA_HI, merged, 4'hF);
        read_reg(can_pkg::REG_DATA_HI, rd);
        if (rd !== merged) show_mismatch("DATA_HI", rd, merged);

        // Partial write, only selected lanes change
        val = $urandom;
        sel = 4'($urandom_range(15, 0));
        write_reg(can_pkg::REG_DATA_HI, val, sel);
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) merged[i*8 +: 8] = val[i*8 +: 8];
        end
        read_reg(can_pkg::REG_DATA_HI, rd);
        if (rd !== merged) show_mismatch("DATA_HI lanes", rd, merged);

        // Let the long count from the random BRP run out
        write_reg(can_pkg::REG_BRP, 32'd0, 4'hF);
        repeat (1100) @(posedge tb_wb_clk_i);

        // Std data first, then ext and RTR mixed, some DLC above 8
        for (int n = 0; n < FRAMES; n++) begin
            load = !(n > 0 && n % 8 == 0);
            if (load) begin
                m_brp  = $urandom_range(7, 1);
                m_id   = 29'($urandom);
                m_ext  = (n >= 12) ? 1'($urandom_range(1, 0)) : 1'b0;
                m_rtr  = (n >= 12) ? ($urandom_range(2, 0) == 0) : 1'b0;
                m_dlc  = (n % 5 == 3) ? 4'($urandom_range(15, 9)) : 4'($urandom_range(8, 0));
                m_data = {$urandom, $urandom};
            end
            // Frame after a busy test resends the old mailbox
            send_frame(load, n % 8 == 7);
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
can_pkg.sv
can_mbox_if.sv
can_bit_if.sv
can_wb_regs.sv
can_bit_timer.sv
can_crc15.sv
can_tx_framer.sv
can_bit_stuffer.sv
can_tx_top.sv
tb_can_tx.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CAN transmit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps -f project.f --top-module tb_can_tx -o tb_can_tx
./obj_dir/tb_can_tx | tee sim.log

if grep -q "Regression failed" sim.log; then
    echo "Simulation reported failure, see sim.log"
    exit 1
fi
echo "Simulation finished, see sim.log"
